/* mem_stage_top.f */
rtl/core_arch_pkg.sv
rtl/mem_stage_pkg.sv
rtl/stage_buffer.sv
rtl/data_ram_access.sv
rtl/writeback_merge.sv
rtl/mem_stage_top.sv
test/clock_gen.sv
test/mem_stage_props.sv
test/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage_top

sources:
  - rtl/core_arch_pkg.sv
  - rtl/mem_stage_pkg.sv
  - rtl/stage_buffer.sv
  - rtl/data_ram_access.sv
  - rtl/writeback_merge.sv
  - rtl/mem_stage_top.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/mem_stage_props.sv
      - test/mem_stage_tb.sv

/* test/mem_stage_tb.sv */
/*
 * Testbench for the memory stage. Drives random execute bundles from a
 * fixed seed on the falling edge, runs a reference model with its own
 * memory image and compares every writeback field each cycle.
 */

`default_nettype none

module mem_stage_tb
        import core_arch_pkg::*;
        import mem_stage_pkg::*;
();

        localparam int CLK_PERIOD = 20;
        localparam int ALU_LEN    = 40;
        localparam int LOAD_LEN   = 64;
        localparam int MEM_LEN    = 120;
        localparam int STALL_LEN  = 60;
        localparam int FLUSH_LEN  = 60;
        localparam int EXC_LEN    = 80;
        localparam int DRAIN_LEN  = 4;
        localparam int TOTAL_LEN  = 5 + RAM_WORDS + ALU_LEN + LOAD_LEN + MEM_LEN +
                                    STALL_LEN + FLUSH_LEN + EXC_LEN + DRAIN_LEN;

        logic         clk;
        logic         reset;
        logic         stall;
        logic         flush;
        ex_bundle_t   ex_in;
        wb_bundle_t   wb_out;

        // Model state. Last bundle accepted, last word read, memory image.
        ex_bundle_t   m_ex;
        logic [31:0]  m_rd;
        logic [31:0]  mem_img [RAM_WORDS];

        int           errors;
        int           checks;
        access_kind_e load_kinds [5] = '{ACC_LDR, ACC_LDRB, ACC_LDRSB, ACC_LDRH, ACC_LDRSH};

        clock_gen u_clock_gen (
                .o_clk   (clk),
                .o_reset (reset)
        );

        mem_stage_top dut (
                .i_clk   (clk),
                .i_reset (reset),
                .i_flush (flush),
                .i_stall (stall),
                .i_ex    (ex_in),
                .o_wb    (wb_out)
        );

        bind mem_stage_top mem_stage_props u_props (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_stall (i_stall),
                .i_flush (i_flush),
                .i_wb    (o_wb)
        );

        function automatic logic [31:0] fill_word(input logic [7:0] a);
                return {a, ~a, a ^ 8'ha5, a + 8'h3c};
        endfunction

        function automatic ex_bundle_t rand_ex(input logic mem_ok, input logic exc_ok);
                ex_bundle_t ex;
                ex             = '0;
                ex.dav         = ($urandom_range(0, 7) != 0);
                ex.alu_result  = 32'($urandom_range(0, 4 * RAM_WORDS - 1));
                ex.store_data  = $urandom();
                ex.flags       = FLAG_W'($urandom_range(0, 15));
                ex.flag_update = 1'($urandom_range(0, 1));
                ex.dest_idx    = REG_IDX_W'($urandom_range(0, PHY_REGS - 1));
                ex.mem_idx     = REG_IDX_W'($urandom_range(0, PHY_REGS - 1));
                ex.pc_plus_8   = $urandom();
                if (mem_ok)
                        ex.kind = access_kind_e'($urandom_range(0, 8));
                else
                        ex.alu_result = $urandom();
                if (exc_ok)
                begin
                        // Some addresses beyond the 1 KiB window.
                        if ($urandom_range(0, 3) == 0)
                                ex.alu_result[31:10] = 22'($urandom_range(1, 4194303));
                        ex.irq    = ($urandom_range(0, 3) == 0);
                        ex.fiq    = ($urandom_range(0, 3) == 0);
                        ex.swi    = ($urandom_range(0, 3) == 0);
                        ex.iabort = ($urandom_range(0, 3) == 0);
                        ex.und    = ($urandom_range(0, 3) == 0);
                end
                return ex;
        endfunction

        // What writeback should show for the bundle held in the model.
        function automatic wb_bundle_t expected_wb();
                wb_bundle_t  e;
                logic        is_load;
                logic        fault;
                logic        ok;
                logic [7:0]  b;
                logic [15:0] h;
                e       = '0;
                is_load = m_ex.kind inside {ACC_LDR, ACC_LDRB, ACC_LDRSB, ACC_LDRH, ACC_LDRSH};
                fault   = m_ex.dav && (m_ex.kind != ACC_NONE) && (m_ex.alu_result[31:10] != '0);
                b       = 8'(m_rd >> (8 * m_ex.alu_result[1:0]));
                h       = m_ex.alu_result[1] ? m_rd[31:16] : m_rd[15:0];
                case (m_ex.kind)
                ACC_LDR:   e.load_data = m_rd;
                ACC_LDRB:  e.load_data = {24'd0, b};
                ACC_LDRSB: e.load_data = {{24{b[7]}}, b};
                ACC_LDRH:  e.load_data = {16'd0, h};
                ACC_LDRSH: e.load_data = {{16{h[15]}}, h};
                default:   e.load_data = 32'd0;
                endcase
                if (m_ex.dav)
                begin
                        if (fault)
                                e.exc = EXC_DABT;
                        else if (m_ex.fiq)
                                e.exc = EXC_FIQ;
                        else if (m_ex.irq)
                                e.exc = EXC_IRQ;
                        else if (m_ex.iabort)
                                e.exc = EXC_PABT;
                        else if (m_ex.und)
                                e.exc = EXC_UND;
                        else if (m_ex.swi)
                                e.exc = EXC_SWI;
                end
                ok          = m_ex.dav && (e.exc == EXC_NONE);
                e.valid     = m_ex.dav;
                e.alu_we    = ok && !is_load;
                e.alu_idx   = m_ex.dest_idx;
                e.alu_data  = m_ex.alu_result;
                e.load_we   = ok && is_load;
                e.load_idx  = m_ex.mem_idx;
                e.flag_we   = ok && m_ex.flag_update;
                e.flags     = m_ex.flags;
                e.pc_plus_8 = m_ex.pc_plus_8;
                return e;
        endfunction

        // Advance the model on a rising edge, from the driven inputs.
        task automatic update_model();
                logic [RAM_AW-1:0] w;
                logic [1:0]        ln;
                logic              in_range;
                w        = ex_in.alu_result[RAM_AW+1:2];
                ln       = ex_in.alu_result[1:0];
                in_range = (ex_in.alu_result[31:10] == '0);
                if (!stall)
                        m_rd = mem_img[w];
                if (flush)
                        m_ex = '0;
                else if (!stall)
                        m_ex = ex_in;
                if (ex_in.dav && in_range && !stall && !flush)
                begin
                        case (ex_in.kind)
                        ACC_STR:  mem_img[w] = ex_in.store_data;
                        ACC_STRB: mem_img[w][8 * ln +: 8] = ex_in.store_data[7:0];
                        ACC_STRH: mem_img[w][16 * ln[1] +: 16] = ex_in.store_data[15:0];
                        default:  ;
                        endcase
                end
        endtask

        task automatic check_field(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                assert (got === exp)
                else
                begin
                        $display("Error: o_wb.%s = 0x%h, expected 0x%h at %0t",
                                 name, got, exp, $time);
                        errors++;
                end
        endtask

        task automatic check_wb();
                wb_bundle_t e;
                e = expected_wb();
                check_field("valid",     32'(wb_out.valid),     32'(e.valid));
                check_field("alu_we",    32'(wb_out.alu_we),    32'(e.alu_we));
                check_field("alu_idx",   32'(wb_out.alu_idx),   32'(e.alu_idx));
                check_field("alu_data",  wb_out.alu_data,       e.alu_data);
                check_field("load_we",   32'(wb_out.load_we),   32'(e.load_we));
                check_field("load_idx",  32'(wb_out.load_idx),  32'(e.load_idx));
                check_field("load_data", wb_out.load_data,      e.load_data);
                check_field("flag_we",   32'(wb_out.flag_we),   32'(e.flag_we));
                check_field("flags",     32'(wb_out.flags),     32'(e.flags));
                check_field("exc",       32'(wb_out.exc),       32'(e.exc));
                check_field("pc_plus_8", wb_out.pc_plus_8,      e.pc_plus_8);
                checks++;
        endtask

        // One cycle. Check the last result, drive, then follow the edge.
        task automatic step(input ex_bundle_t ex, input logic st, input logic fl);
                @(negedge clk);
                check_wb();
                ex_in = ex;
                stall = st;
                flush = fl;
                @(posedge clk);
                update_model();
        endtask

        task automatic report_test(input string name, input int cycles, input int err_before);
                $display("test %-12s %4d cycles, %0d errors", name, cycles, errors - err_before);
        endtask

        initial
        begin : main
                ex_bundle_t ex;
                int         err0;
                void'($urandom(33));
                ex_in  = '0;
                stall  = 1'b0;
                flush  = 1'b0;
                m_ex   = '0;
                m_rd   = '0;
                errors = 0;
                checks = 0;
                @(negedge reset);

                // Known contents first, so every later load has a defined value.
                err0 = errors;
                for (int i = 0; i < RAM_WORDS; i++)
                begin
                        ex            = '0;
                        ex.dav        = 1'b1;
                        ex.kind       = ACC_STR;
                        ex.alu_result = 32'(4 * i);
                        ex.store_data = fill_word(8'(i));
                        step(ex, 1'b0, 1'b0);
                end
                report_test("mem_fill", RAM_WORDS, err0);

                err0 = errors;
                for (int i = 0; i < ALU_LEN; i++)
                        step(rand_ex(1'b0, 1'b0), 1'b0, 1'b0);
                report_test("alu_pass", ALU_LEN, err0);

                // Every load kind on every lane.
                err0 = errors;
                for (int i = 0; i < LOAD_LEN; i++)
                begin
                        ex                  = rand_ex(1'b1, 1'b0);
                        ex.dav              = 1'b1;
                        ex.kind             = load_kinds[(i / 4) % 5];
                        ex.alu_result[1:0]  = 2'(i);
                        step(ex, 1'b0, 1'b0);
                end
                report_test("load_align", LOAD_LEN, err0);

                err0 = errors;
                for (int i = 0; i < MEM_LEN; i++)
                        step(rand_ex(1'b1, 1'b0), 1'b0, 1'b0);
                report_test("store_load", MEM_LEN, err0);

                err0 = errors;
                for (int i = 0; i < STALL_LEN; i++)
                        step(rand_ex(1'b1, 1'b0), ($urandom_range(0, 2) == 0), 1'b0);
                report_test("stall", STALL_LEN, err0);

                // Stall mixed in so that flush has to win over it.
                err0 = errors;
                for (int i = 0; i < FLUSH_LEN; i++)
                        step(rand_ex(1'b1, 1'b0), ($urandom_range(0, 5) == 0),
                             ($urandom_range(0, 3) == 0));
                report_test("flush", FLUSH_LEN, err0);

                err0 = errors;
                for (int i = 0; i < EXC_LEN; i++)
                        step(rand_ex(1'b1, 1'b1), 1'b0, 1'b0);
                report_test("exceptions", EXC_LEN, err0);

                for (int i = 0; i < DRAIN_LEN; i++)
                        step('0, 1'b0, 1'b0);
                @(negedge clk);
                check_wb();
                errors += dut.u_props.fail_count;

                $display("%0d cycles checked, %0d errors", checks, errors);
                if (errors == 0)
                        $display("** PASS **");
                else
                        $display("** FAIL **");
                $finish;
        end

        initial
        begin
                #((TOTAL_LEN + 200) * CLK_PERIOD);
                $display("Timeout: tests did not finish within %0d cycles", TOTAL_LEN + 200);
                $display("** FAIL **");
                $finish;
        end

endmodule

`default_nettype wire

/* test/mem_stage_props.sv */
/*
 * Concurrent checks on the memory stage outputs.
 * Bound into mem_stage_top from the testbench.
 */

`default_nettype none

module mem_stage_props
        import core_arch_pkg::*;
        import mem_stage_pkg::*;
(
        input logic       i_clk,
        input logic       i_reset,
        input logic       i_stall,
        input logic       i_flush,
        input wb_bundle_t i_wb
);

        // Number of failed assertions.
        int fail_count = 0;

        // Nothing comes out of a freshly reset stage.
        a_reset_clears: assert property (@(posedge i_clk) i_reset |=> !i_wb.valid)
        else
        begin
                $error("o_wb.valid high in the cycle after reset");
                fail_count++;
        end

        // A stall without flush freezes the whole writeback bundle.
        a_stall_holds: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_stall && !i_flush) |=> $stable(i_wb))
        else
        begin
                $error("o_wb changed across a stalled cycle");
                fail_count++;
        end

        a_exc_blocks_writes: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_wb.exc != EXC_NONE) |-> !(i_wb.alu_we || i_wb.load_we || i_wb.flag_we))
        else
        begin
                $error("register or flag write enabled with an exception taken");
                fail_count++;
        end

endmodule

`default_nettype wire

/* test/clock_gen.sv */
/*
 * Clock and reset source for the memory stage testbench.
 * Period of 20, reset held high over the first five rising edges.
 */

`default_nettype none

module clock_gen
(
        output logic o_clk,
        output logic o_reset
);

        initial
        begin
                o_clk = 1'b0;
                forever #10 o_clk = ~o_clk;
        end

        // Released on a falling edge, away from the sampling edge.
        initial
        begin
                o_reset = 1'b1;
                repeat (5) @(posedge o_clk);
                @(negedge o_clk);
                o_reset = 1'b0;
        end

endmodule

`default_nettype wire

/* rtl/mem_stage_top.sv */
/*
 * Memory stage of the pipeline. The execute bundle is buffered and the
 * RAM is accessed in parallel; both meet in the writeback bundle one
 * cycle later.
 */

`default_nettype none

module mem_stage_top
        import mem_stage_pkg::*;
(
        input  logic       i_clk,
        input  logic       i_reset,

        // Flush pulse from writeback, stall level from the hazard logic.
        input  logic       i_flush,
        input  logic       i_stall,

        input  ex_bundle_t i_ex,
        output wb_bundle_t o_wb
);

        buf_bundle_t buf_q;
        mem_result_t mem_res;

        stage_buffer u_stage_buffer (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_flush (i_flush),
                .i_stall (i_stall),
                .i_ex    (i_ex),
                .o_buf   (buf_q)
        );

        data_ram_access u_data_ram_access (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_flush (i_flush),
                .i_stall (i_stall),
                .i_ex    (i_ex),
                .o_mem   (mem_res)
        );

        // No register here, results line up already.
        writeback_merge u_writeback_merge (
                .i_buf (buf_q),
                .i_mem (mem_res),
                .o_wb  (o_wb)
        );

endmodule

`default_nettype wire

/* rtl/writeback_merge.sv */
/*
 * Joins the buffered execute bundle with the memory result to form the
 * writeback bundle. Picks the highest priority exception and blocks
 * all register and flag writes when one is taken. Purely combinational.
 */

`default_nettype none

module writeback_merge
        import core_arch_pkg::*;
        import mem_stage_pkg::*;
(
        input  buf_bundle_t i_buf,
        input  mem_result_t i_mem,
        output wb_bundle_t  o_wb
);

        exc_code_e exc;
        logic      exc_taken;
        logic      write_ok;

        /*
         * Data abort from this stage outranks everything that came
         * down the pipe; the rest follow the enum order.
         */
        always_comb
        begin
                exc = EXC_NONE;
                if (i_buf.dav)
                begin
                        if (i_mem.fault)
                                exc = EXC_DABT;
                        else if (i_buf.fiq)
                                exc = EXC_FIQ;
                        else if (i_buf.irq)
                                exc = EXC_IRQ;
                        else if (i_buf.iabort)
                                exc = EXC_PABT;
                        else if (i_buf.und)
                                exc = EXC_UND;
                        else if (i_buf.swi)
                                exc = EXC_SWI;
                end
        end

        assign exc_taken = (exc != EXC_NONE);
        assign write_ok  = i_buf.dav && !exc_taken;

        always_comb
        begin
                o_wb.valid     = i_buf.dav;

                // ALU port, off for loads.
                o_wb.alu_we    = write_ok && !i_mem.is_load;
                o_wb.alu_idx   = i_buf.dest_idx;
                o_wb.alu_data  = i_buf.alu_result;

                // Load port goes to the memory source/destination register.
                o_wb.load_we   = write_ok && i_mem.is_load;
                o_wb.load_idx  = i_buf.mem_idx;
                o_wb.load_data = i_mem.load_data;

                o_wb.flag_we   = write_ok && i_buf.flag_update;
                o_wb.flags     = i_buf.flags;

                o_wb.exc       = exc;
                o_wb.pc_plus_8 = i_buf.pc_plus_8;
        end

endmodule

`default_nettype wire

/* rtl/data_ram_access.sv */
/*
 * Single-cycle data RAM port of the memory stage.
 * Stores go in with per-byte lane enables; loads are read synchronously
 * and then aligned and zero or sign extended from the registered kind.
 */

`default_nettype none

module data_ram_access
        import core_arch_pkg::*;
        import mem_stage_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_flush,
        input  logic        i_stall,

        input  ex_bundle_t  i_ex,
        output mem_result_t o_mem
);

        logic [31:0]       ram [RAM_WORDS];

        logic [RAM_AW-1:0] word_addr;
        logic [1:0]        lane;
        logic              out_of_range;
        logic              is_access;
        logic              is_store;
        logic              store_en;
        logic [3:0]        byte_en;
        logic [31:0]       wr_data;

        // Read side, registered with the read data.
        logic [31:0]       rd_data_ff;
        access_kind_e      kind_ff;
        logic [1:0]        lane_ff;
        logic              fault_ff;

        logic [7:0]        rd_byte;
        logic [15:0]       rd_half;

        assign word_addr    = i_ex.alu_result[RAM_AW+1:2];
        assign lane         = i_ex.alu_result[1:0];
        assign out_of_range = |i_ex.alu_result[31:RAM_AW+2];
        assign is_access    = i_ex.dav && (i_ex.kind != ACC_NONE);
        assign is_store     = (i_ex.kind == ACC_STR) || (i_ex.kind == ACC_STRB) ||
                              (i_ex.kind == ACC_STRH);
        assign store_en     = i_ex.dav && is_store && !out_of_range && !i_stall && !i_flush;

        // Lane enables and replicated write data.
        always_comb
        begin
                unique case (i_ex.kind)
                ACC_STRB:
                begin
                        byte_en = 4'b0001 << lane;
                        wr_data = {4{i_ex.store_data[7:0]}};
                end
                ACC_STRH:
                begin
                        byte_en = lane[1] ? 4'b1100 : 4'b0011;
                        wr_data = {2{i_ex.store_data[15:0]}};
                end
                default:
                begin
                        byte_en = 4'b1111;
                        wr_data = i_ex.store_data;
                end
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (store_en)
                begin
                        for (int i = 0; i < 4; i++)
                        begin
                                if (byte_en[i])
                                        ram[word_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
                        end
                end
                if (!i_stall)
                        rd_data_ff <= ram[word_addr];
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        kind_ff  <= ACC_NONE;
                        lane_ff  <= 2'd0;
                        fault_ff <= 1'b0;
                end
                else if (!i_stall)
                begin
                        kind_ff  <= i_ex.kind;
                        lane_ff  <= lane;
                        fault_ff <= is_access && out_of_range;
                end
        end

        assign rd_byte = rd_data_ff[{lane_ff, 3'b000} +: 8];
        assign rd_half = lane_ff[1] ? rd_data_ff[31:16] : rd_data_ff[15:0];

        // Word loads ignore the low address bits.
        always_comb
        begin
                o_mem.fault   = fault_ff;
                o_mem.is_load = 1'b1;
                unique case (kind_ff)
                ACC_LDR:   o_mem.load_data = rd_data_ff;
                ACC_LDRB:  o_mem.load_data = {24'd0, rd_byte};
                ACC_LDRSB: o_mem.load_data = {{24{rd_byte[7]}}, rd_byte};
                ACC_LDRH:  o_mem.load_data = {16'd0, rd_half};
                ACC_LDRSH: o_mem.load_data = {{16{rd_half[15]}}, rd_half};
                default:
                begin
                        o_mem.is_load   = 1'b0;
                        o_mem.load_data = 32'd0;
                end
                endcase
        end

endmodule

`default_nettype wire

/* rtl/stage_buffer.sv */
/*
 * Pipeline register between execute and writeback for everything except
 * the store data. Clears on reset or a flush from writeback, holds while
 * stalled and otherwise takes the new bundle every cycle.
 */

`default_nettype none

module stage_buffer
        import mem_stage_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,

        // Pipeline control.
        input  logic        i_flush,
        input  logic        i_stall,

        input  ex_bundle_t  i_ex,
        output buf_bundle_t o_buf
);

        buf_bundle_t buf_next;

        // Drop store data, the RAM unit has already used it.
        always_comb
        begin
                buf_next.dav         = i_ex.dav;
                buf_next.alu_result  = i_ex.alu_result;
                buf_next.flags       = i_ex.flags;
                buf_next.flag_update = i_ex.flag_update;
                buf_next.dest_idx    = i_ex.dest_idx;
                buf_next.mem_idx     = i_ex.mem_idx;
                buf_next.pc_plus_8   = i_ex.pc_plus_8;
                buf_next.kind        = i_ex.kind;
                buf_next.irq         = i_ex.irq;
                buf_next.fiq         = i_ex.fiq;
                buf_next.swi         = i_ex.swi;
                buf_next.iabort      = i_ex.iabort;
                buf_next.und         = i_ex.und;
        end

        /*
         * Flush wins over stall, so a flushed slot never lingers
         * behind a stall and resurfaces later.
         */
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_buf <= '0;
                end
                else if (i_flush)
                begin
                        o_buf <= '0;
                end
                else if (!i_stall)
                begin
                        o_buf <= buf_next;
                end
                // Stalled, hold everything.
        end

endmodule

`default_nettype wire

/* rtl/mem_stage_pkg.sv */
/*
 * Bundles that pass through the memory stage, and the data RAM size.
 * Execute hands over ex_bundle_t; writeback receives wb_bundle_t.
 */

`default_nettype none

package mem_stage_pkg;

        import core_arch_pkg::*;

        // 1 KiB of word-wide data RAM.
        localparam int RAM_WORDS = 256;
        localparam int RAM_AW    = $clog2(RAM_WORDS);

        // From the execute stage.
        typedef struct packed {
                logic                 dav;
                logic [31:0]          alu_result;
                logic [31:0]          store_data;
                logic [FLAG_W-1:0]    flags;
                logic                 flag_update;
                logic [REG_IDX_W-1:0] dest_idx;
                logic [REG_IDX_W-1:0] mem_idx;
                logic [31:0]          pc_plus_8;
                access_kind_e         kind;
                logic                 irq;
                logic                 fiq;
                logic                 swi;
                logic                 iabort;
                logic                 und;
        } ex_bundle_t;

        // Registered copy, store data stays behind.
        typedef struct packed {
                logic                 dav;
                logic [31:0]          alu_result;
                logic [FLAG_W-1:0]    flags;
                logic                 flag_update;
                logic [REG_IDX_W-1:0] dest_idx;
                logic [REG_IDX_W-1:0] mem_idx;
                logic [31:0]          pc_plus_8;
                access_kind_e         kind;
                logic                 irq;
                logic                 fiq;
                logic                 swi;
                logic                 iabort;
                logic                 und;
        } buf_bundle_t;

        typedef struct packed {
                logic        is_load;
                logic        fault;
                logic [31:0] load_data;
        } mem_result_t;

        // To the register file.
        typedef struct packed {
                logic                 valid;
                logic                 alu_we;
                logic [REG_IDX_W-1:0] alu_idx;
                logic [31:0]          alu_data;
                logic                 load_we;
                logic [REG_IDX_W-1:0] load_idx;
                logic [31:0]          load_data;
                logic                 flag_we;
                logic [FLAG_W-1:0]    flags;
                exc_code_e            exc;
                logic [31:0]          pc_plus_8;
        } wb_bundle_t;

endpackage

`default_nettype wire

/* rtl/core_arch_pkg.sv */
/*
 * Architectural constants and encodings of the core.
 * Register file geometry, NZCV flag width, memory access kinds and
 * exception codes. Import into any block that decodes these values.
 */

`default_nettype none

package core_arch_pkg;

        // Physical register file, including banked copies.
        localparam int PHY_REGS  = 46;
        localparam int REG_IDX_W = $clog2(PHY_REGS);

        // N, Z, C and V.
        localparam int FLAG_W    = 4;

        // Memory access kind carried down from decode.
        typedef enum logic [3:0] {
                ACC_NONE  = 4'd0,
                ACC_LDR   = 4'd1,
                ACC_LDRB  = 4'd2,
                ACC_LDRSB = 4'd3,
                ACC_LDRH  = 4'd4,
                ACC_LDRSH = 4'd5,
                ACC_STR   = 4'd6,
                ACC_STRB  = 4'd7,
                ACC_STRH  = 4'd8
        } access_kind_e;

        // Listed highest priority first, after none.
        typedef enum logic [2:0] {
                EXC_NONE = 3'd0,
                EXC_DABT = 3'd1,
                EXC_FIQ  = 3'd2,
                EXC_IRQ  = 3'd3,
                EXC_PABT = 3'd4,
                EXC_UND  = 3'd5,
                EXC_SWI  = 3'd6
        } exc_code_e;

endpackage

`default_nettype wire
